//--- fire_squeeze.f
verilog/squeeze_pkg.sv
verilog/squeeze_weight_rom.sv
verilog/squeeze_sequencer.sv
verilog/squeeze_mac.sv
verilog/squeeze_output_stage.sv
verilog/fire_squeeze.sv
tb/fire_squeeze_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run fire_squeeze_tb with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f fire_squeeze.f \
	--top-module fire_squeeze_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/Vfire_squeeze_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- squeeze_bias.hex
// One 32-bit bias per filter, filter 0 first
00002000
FFFFC000
00010000
00000400

//--- squeeze_weights.hex
// Columns filter 3, filter 2, filter 1, filter 0 (16-bit Q14), one row per input channel
1800E00008001000
E800F000F8001000
0600F80004001000
FA00F00020001000
3000F400FC001000
D000F0000C001000
0100FC0002001000
FF00F000FE001000

//--- tb/fire_squeeze_tb.sv
`timescale 1ns/1ps

module fire_squeeze_tb;

	logic clk;
	logic reset;
	logic ifm_en;
	squeeze_pkg::word_t ifm;
	logic ram_feedback;
	squeeze_pkg::word_t ofm [squeeze_pkg::FILTERS];
	logic ofm_sample;
	logic layer_finish;

	// Reference copies of the ROM contents
	logic [squeeze_pkg::FILTERS*squeeze_pkg::DATA_W-1:0]
		weight_ref [squeeze_pkg::CHANNELS_IN];
	logic [squeeze_pkg::ACC_W-1:0] bias_ref [squeeze_pkg::FILTERS];

	// Stimulus rows and expected outputs
	// The last row arrives after the layer has ended
	squeeze_pkg::word_t pix_table [squeeze_pkg::PIXELS_OUT+1][squeeze_pkg::CHANNELS_IN];
	int gap_table [squeeze_pkg::PIXELS_OUT+1];
	logic [15:0] exp_table [squeeze_pkg::PIXELS_OUT+1][squeeze_pkg::FILTERS];

	int error_count = 0;
	int budget = 50;
	bit table_ready = 1'b0;
	// Monitor state
	int unsigned neg_cnt = 0;
	int strobe_cnt = 0;
	int samples_seen = 0;
	int unsigned due_q [$];

	fire_squeeze dut_i (
		.clk(clk),
		.reset(reset),
		.ifm_en(ifm_en),
		.ifm(ifm),
		.ram_feedback(ram_feedback),
		.ofm(ofm),
		.ofm_sample(ofm_sample),
		.layer_finish(layer_finish)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// Reporting
	//////////////////////////////

	task automatic report_failure(input string reason);
		error_count++;
		$display("%0t ns: %s", $time, reason);
		$display("Something failed");
		$fatal(1, "testbench stopped on error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("Something failed");
			$fatal(1, "testbench stopped on mismatch");
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Dot product plus bias, ReLU, then Q14 down to an integer mod 2^15
	function automatic logic [15:0] model_ofm(input int row, input int f);
		logic signed [31:0] sum;
		logic signed [31:0] pix;
		logic signed [31:0] wgt;
		sum = bias_ref[f];
		for (int c = 0; c < squeeze_pkg::CHANNELS_IN; c++) begin
			pix = pix_table[row][c];
			wgt = $signed(weight_ref[c][f*squeeze_pkg::DATA_W +: squeeze_pkg::DATA_W]);
			sum = sum + pix * wgt;
		end
		if (sum < 0)
			return 16'h0000;
		return 16'((sum >>> squeeze_pkg::FRAC_SHIFT) & 32'h7FFF);
	endfunction

	task automatic build_table();
		void'($urandom(60));
		// Full scale row drives filter 0 past 2^29
		for (int c = 0; c < squeeze_pkg::CHANNELS_IN; c++)
			pix_table[0][c] = 16'h7FFF;
		// Zeros and most negative values turn filters 0 and 1 negative
		pix_table[1] = '{16'h0000, 16'h8000, 16'h0000, 16'h8000,
			16'h7FFF, 16'h0000, 16'h8000, 16'h0001};
		for (int r = 2; r <= squeeze_pkg::PIXELS_OUT; r++)
			for (int c = 0; c < squeeze_pkg::CHANNELS_IN; c++)
				pix_table[r][c] = 16'($urandom());
		// Idle cycles after each strobe
		gap_table = '{0, 2, 0, 1, 0};
		for (int r = 0; r <= squeeze_pkg::PIXELS_OUT; r++) begin
			for (int f = 0; f < squeeze_pkg::FILTERS; f++)
				exp_table[r][f] = model_ofm(r, f);
			budget += squeeze_pkg::CHANNELS_IN * (1 + gap_table[r]) + 4;
		end
		table_ready = 1'b1;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic apply_row(input int row);
		for (int c = 0; c < squeeze_pkg::CHANNELS_IN; c++) begin
			@(posedge clk);
			ifm_en <= 1'b1;
			ifm <= pix_table[row][c];
			// Junk on ifm while idle
			for (int g = 0; g < gap_table[row]; g++) begin
				@(posedge clk);
				ifm_en <= 1'b0;
				ifm <= 16'h5A5A;
			end
		end
	endtask

	// Outputs are stable at falling edges
	always @(negedge clk) begin
		neg_cnt++;
		if (!reset) begin
			// Strobe seen here is taken at the next rising edge
			// Strobes past the layer end get no due entry
			if (ifm_en && strobe_cnt < squeeze_pkg::PIXELS_OUT * squeeze_pkg::CHANNELS_IN) begin
				strobe_cnt++;
				if (strobe_cnt % squeeze_pkg::CHANNELS_IN == 0)
					due_q.push_back(neg_cnt + 3);
			end
			if (ofm_sample) begin
				if (due_q.size() == 0) begin
					report_failure("ofm_sample pulsed with no finished pixel pending");
				end else begin
					check_value(32'(neg_cnt), 32'(due_q.pop_front()), "ofm_sample timing");
					for (int f = 0; f < squeeze_pkg::FILTERS; f++)
						check_value({16'h0000, ofm[f]},
							{16'h0000, exp_table[samples_seen][f]},
							$sformatf("ofm[%0d] of pixel %0d", f, samples_seen));
					samples_seen++;
				end
			end else if (due_q.size() != 0 && due_q[0] <= neg_cnt) begin
				report_failure("ofm_sample missing two cycles after the last channel strobe");
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		reset = 1'b1;
		ifm_en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		$readmemh("squeeze_weights.hex", weight_ref);
		$readmemh("squeeze_bias.hex", bias_ref);
		build_table();
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Idle outputs after reset
		@(negedge clk);
		check_value(32'(ofm_sample), 32'd0, "ofm_sample after reset");
		check_value(32'(layer_finish), 32'd0, "layer_finish after reset");
		for (int f = 0; f < squeeze_pkg::FILTERS; f++)
			check_value({16'h0000, ofm[f]}, 32'd0, $sformatf("ofm[%0d] after reset", f));

		for (int r = 0; r < squeeze_pkg::PIXELS_OUT; r++)
			apply_row(r);
		@(posedge clk);
		ifm_en <= 1'b0;
		wait (samples_seen == squeeze_pkg::PIXELS_OUT);
		@(negedge clk);
		check_value(32'(layer_finish), 32'd1, "layer_finish after last pixel");

		// The closed layer drops this row
		apply_row(squeeze_pkg::PIXELS_OUT);
		@(posedge clk);
		ifm_en <= 1'b0;
		repeat (6) @(negedge clk);
		check_value(32'(layer_finish), 32'd1, "layer_finish before ram_feedback");

		// Downstream ack
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		repeat (10) begin
			@(negedge clk);
			check_value(32'(layer_finish), 32'd0, "layer_finish after ram_feedback");
		end

		if (error_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "checks failed");
		end
	end

	// Watchdog starts once the table and its budget exist
	initial begin
		wait (table_ready);
		repeat (budget) @(posedge clk);
		report_failure($sformatf("timeout, run did not end within %0d cycles", budget));
	end

endmodule

//--- verilog/fire_squeeze.sv
`timescale 1ns/1ps

module fire_squeeze (
	input logic clk,
	input logic reset,
	input logic ifm_en,
	input squeeze_pkg::word_t ifm,
	input logic ram_feedback,
	output squeeze_pkg::word_t ofm [squeeze_pkg::FILTERS],
	output logic ofm_sample,
	output logic layer_finish
);

	logic [squeeze_pkg::CH_ADDR_W-1:0] ch_addr;
	squeeze_pkg::word_t rom_weights [squeeze_pkg::FILTERS];
	squeeze_pkg::acc_t bias_words [squeeze_pkg::FILTERS];
	squeeze_pkg::word_t pix_q;
	squeeze_pkg::word_t ker_q [squeeze_pkg::FILTERS];
	logic mac_en;
	logic mac_first;
	logic sum_done;
	squeeze_pkg::acc_t acc [squeeze_pkg::FILTERS];

	//////////////////////////////
	// Weights and control
	//////////////////////////////

	squeeze_weight_rom rom_i (
		.ch_addr(ch_addr),
		.rom_weights(rom_weights),
		.bias_words(bias_words)
	);

	squeeze_sequencer seq_i (
		.clk(clk),
		.reset(reset),
		.ifm_en(ifm_en),
		.ifm(ifm),
		.rom_weights(rom_weights),
		.ram_feedback(ram_feedback),
		.ch_addr(ch_addr),
		.pix_q(pix_q),
		.ker_q(ker_q),
		.mac_en(mac_en),
		.mac_first(mac_first),
		.sum_done(sum_done),
		.layer_finish(layer_finish)
	);

	//////////////////////////////
	// MAC lanes
	//////////////////////////////

	// Same pixel into every lane, own weight each
	for (genvar i = 0; i < squeeze_pkg::FILTERS; i++) begin : g_lane
		squeeze_mac mac_i (
			.clk(clk),
			.reset(reset),
			.mac_en(mac_en),
			.mac_first(mac_first),
			.pix(pix_q),
			.ker(ker_q[i]),
			.acc(acc[i])
		);
	end

	squeeze_output_stage out_i (
		.clk(clk),
		.reset(reset),
		.sum_done(sum_done),
		.acc(acc),
		.bias_words(bias_words),
		.ofm(ofm),
		.ofm_sample(ofm_sample)
	);

endmodule

//--- verilog/squeeze_mac.sv
`timescale 1ns/1ps

module squeeze_mac (
	input logic clk,
	input logic reset,
	input logic mac_en,
	input logic mac_first,
	input squeeze_pkg::word_t pix,
	input squeeze_pkg::word_t ker,
	output squeeze_pkg::acc_t acc
);

	squeeze_pkg::acc_t prod;

	// Full-width signed product, no overflow for 16x16
	assign prod = squeeze_pkg::acc_t'(pix) * squeeze_pkg::acc_t'(ker);

	//////////////////////////////
	// Accumulator
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			acc <= '0;
		else if (mac_en) begin
			// First channel drops the previous pixel's sum
			if (mac_first)
				acc <= prod;
			else
				acc <= acc + prod;
		end
	end

	// Sum must hold between strobes so gaps are harmless
	hold_without_en: assert property (@(posedge clk) disable iff (reset)
		!mac_en |=> $stable(acc));

endmodule

//--- verilog/squeeze_output_stage.sv
`timescale 1ns/1ps

module squeeze_output_stage (
	input logic clk,
	input logic reset,
	input logic sum_done,
	input squeeze_pkg::acc_t acc [squeeze_pkg::FILTERS],
	input squeeze_pkg::acc_t bias_words [squeeze_pkg::FILTERS],
	output squeeze_pkg::word_t ofm [squeeze_pkg::FILTERS],
	output logic ofm_sample
);

	squeeze_pkg::acc_t biased [squeeze_pkg::FILTERS];
	squeeze_pkg::word_t quant [squeeze_pkg::FILTERS];

	//////////////////////////////
	// Bias, ReLU, requantize
	//////////////////////////////

	always_comb begin
		for (int f = 0; f < squeeze_pkg::FILTERS; f++) begin
			// Wraps on overflow, same as the ACC_W adder
			biased[f] = acc[f] + bias_words[f];
		end
	end

	always_comb begin
		for (int f = 0; f < squeeze_pkg::FILTERS; f++) begin
			// Negative sum clamps to zero
			if (biased[f][squeeze_pkg::ACC_W-1])
				quant[f] = '0;
			else
				// Sign bit then bits 28..14, upper bits dropped
				quant[f] = {1'b0,
					biased[f][squeeze_pkg::FRAC_SHIFT +: squeeze_pkg::DATA_W-1]};
		end
	end

	//////////////////////////////
	// Output registers
	//////////////////////////////

	// ofm holds until the next pixel completes
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int f = 0; f < squeeze_pkg::FILTERS; f++) begin
				ofm[f] <= '0;
			end
		end else if (sum_done) begin
			for (int f = 0; f < squeeze_pkg::FILTERS; f++) begin
				ofm[f] <= quant[f];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			ofm_sample <= 1'b0;
		else
			ofm_sample <= sum_done;
	end

	// Pixels take at least CHANNELS_IN strobes, so samples never touch
	sample_single: assert property (@(posedge clk) disable iff (reset)
		ofm_sample |=> !ofm_sample);

endmodule

//--- verilog/squeeze_pkg.sv
package squeeze_pkg;

	//////////////////////////////
	// Layer sizes
	//////////////////////////////

	// Input channels summed per output pixel
	localparam int CHANNELS_IN = 8;
	// MAC lanes, one per output filter
	localparam int FILTERS = 4;
	// Output pixels before the layer reports done
	localparam int PIXELS_OUT = 4;

	//////////////////////////////
	// Word widths
	//////////////////////////////

	// Pixel, weight and output word
	localparam int DATA_W = 16;
	// Accumulator and bias
	localparam int ACC_W = 32;
	// Requantization shift, Q14 weights
	localparam int FRAC_SHIFT = 14;

	// Channel address into the weight ROM
	localparam int CH_ADDR_W = 3;
	// Output pixel counter, must reach PIXELS_OUT
	localparam int PIX_CNT_W = 3;

	typedef logic signed [DATA_W-1:0] word_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	//////////////////////////////
	// Sequencer state
	//////////////////////////////

	typedef enum logic [0:0] {
		// Accepting channel strobes
		LAYER_RUN = 1'b0,
		// All output pixels produced
		LAYER_DONE = 1'b1
	} layer_state_t;

endpackage

//--- verilog/squeeze_sequencer.sv
`timescale 1ns/1ps

module squeeze_sequencer (
	input logic clk,
	input logic reset,
	input logic ifm_en,
	input squeeze_pkg::word_t ifm,
	input squeeze_pkg::word_t rom_weights [squeeze_pkg::FILTERS],
	input logic ram_feedback,
	output logic [squeeze_pkg::CH_ADDR_W-1:0] ch_addr,
	output squeeze_pkg::word_t pix_q,
	output squeeze_pkg::word_t ker_q [squeeze_pkg::FILTERS],
	output logic mac_en,
	output logic mac_first,
	output logic sum_done,
	output logic layer_finish
);

	squeeze_pkg::layer_state_t state;
	logic [squeeze_pkg::CH_ADDR_W-1:0] ch_cnt;
	logic [squeeze_pkg::PIX_CNT_W-1:0] pix_cnt;
	logic accept;
	logic last_ch;
	logic last_q;
	logic feedback_seen;

	// Strobes count only while the layer runs
	assign accept = ifm_en && (state == squeeze_pkg::LAYER_RUN);
	assign last_ch = (ch_cnt == (squeeze_pkg::CH_ADDR_W)'(squeeze_pkg::CHANNELS_IN - 1));

	// ROM row follows the channel counter
	assign ch_addr = ch_cnt;

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Pixel and weights line up with mac_en
	always_ff @(posedge clk) begin
		if (accept) begin
			pix_q <= ifm;
			ker_q <= rom_weights;
		end
	end

	//////////////////////////////
	// Channel count and strobes
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ch_cnt <= '0;
			mac_en <= 1'b0;
			mac_first <= 1'b0;
			last_q <= 1'b0;
			sum_done <= 1'b0;
		end else begin
			mac_en <= accept;
			// Restart the lanes on channel 0
			mac_first <= accept && (ch_cnt == '0);
			last_q <= accept && last_ch;
			// Lanes hold the full sum one edge after the last MAC
			sum_done <= last_q;
			if (accept) begin
				if (last_ch)
					ch_cnt <= '0;
				else
					ch_cnt <= ch_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Pixel count and layer end
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			state <= squeeze_pkg::LAYER_RUN;
		end else if (sum_done) begin
			pix_cnt <= pix_cnt + 1'b1;
			if (pix_cnt == (squeeze_pkg::PIX_CNT_W)'(squeeze_pkg::PIXELS_OUT - 1))
				state <= squeeze_pkg::LAYER_DONE;
		end
	end

	// Downstream RAM ack, sticky
	always_ff @(posedge clk) begin
		if (reset)
			feedback_seen <= 1'b0;
		else if (ram_feedback)
			feedback_seen <= 1'b1;
	end

	assign layer_finish = (state == squeeze_pkg::LAYER_DONE) && !feedback_seen;

	//////////////////////////////
	// Checks
	//////////////////////////////

	first_has_en: assert property (@(posedge clk) disable iff (reset)
		mac_first |-> mac_en);

	// A pixel that ends after the layer closes would be lost
	no_done_after_end: assert property (@(posedge clk) disable iff (reset)
		sum_done |-> (state == squeeze_pkg::LAYER_RUN));

	pix_cnt_bound: assert property (@(posedge clk) disable iff (reset)
		pix_cnt <= (squeeze_pkg::PIX_CNT_W)'(squeeze_pkg::PIXELS_OUT));

endmodule

//--- verilog/squeeze_weight_rom.sv
`timescale 1ns/1ps

module squeeze_weight_rom (
	input logic [squeeze_pkg::CH_ADDR_W-1:0] ch_addr,
	output squeeze_pkg::word_t rom_weights [squeeze_pkg::FILTERS],
	output squeeze_pkg::acc_t bias_words [squeeze_pkg::FILTERS]
);

	//////////////////////////////
	// Memories
	//////////////////////////////

	// One row per input channel, filter 0 in the low bits
	logic [squeeze_pkg::FILTERS*squeeze_pkg::DATA_W-1:0]
		weight_mem [squeeze_pkg::CHANNELS_IN];

	// One bias word per filter
	squeeze_pkg::acc_t bias_mem [squeeze_pkg::FILTERS];

	// Contents fixed at elaboration
	initial begin
		$readmemh("squeeze_weights.hex", weight_mem);
		$readmemh("squeeze_bias.hex", bias_mem);
	end

	//////////////////////////////
	// Asynchronous read
	//////////////////////////////

	// Split the addressed row into per-filter weights
	always_comb begin
		for (int f = 0; f < squeeze_pkg::FILTERS; f++) begin
			rom_weights[f] = weight_mem[ch_addr][f*squeeze_pkg::DATA_W +: squeeze_pkg::DATA_W];
		end
	end

	// Biases do not depend on the channel
	always_comb begin
		for (int f = 0; f < squeeze_pkg::FILTERS; f++) begin
			bias_words[f] = bias_mem[f];
		end
	end

endmodule
